/* vload_cfg.svh */
`ifndef VLOAD_CFG_SVH
`define VLOAD_CFG_SVH

////////////////////////////////////////////////////////////
// AXI side
////////////////////////////////////////////////////////////

// Byte address width of the AXI read master
`define VLOAD_ADDR_W 32

// Beat width, also the width of one buffer word
`define VLOAD_DATA_W 64

// Beats in a full burst, 16 beats of 8 bytes give 128 bytes
`define VLOAD_BURST_LEN 16

// Bursts allowed in flight at once
`define VLOAD_MAX_OUTSTANDING 4

////////////////////////////////////////////////////////////
// Vector register buffer
////////////////////////////////////////////////////////////

// Buffer depth in words, caps one load at 512 bytes
`define VLOAD_VRF_WORDS 64

`endif

/* vload_pkg.sv */
`include "vload_cfg.svh"

package vload_pkg;

  ////////////////////////////////////////////////////////////
  // Plain widths
  ////////////////////////////////////////////////////////////

  // AXI byte address
  typedef logic [`VLOAD_ADDR_W-1:0] addr_t;

  // One read beat or one buffer word
  typedef logic [`VLOAD_DATA_W-1:0] data_t;

  // APB data bus
  typedef logic [31:0] apb_word_t;

  // Beat count, 0 up to 64 inclusive
  typedef logic [6:0] beat_cnt_t;

  // Buffer word index
  typedef logic [5:0] vrf_idx_t;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Read address payload, len is beats minus one
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
  } axi_ar_t;

  // Read data payload
  typedef struct packed {
    data_t data;
    logic  last;
  } axi_r_t;

  // Load request as sampled at start, size in bytes
  typedef struct packed {
    addr_t addr;
    addr_t size;
  } load_req_t;

  // Register block control state
  typedef enum logic {
    CTRL_IDLE,
    CTRL_BUSY
  } ctrl_state_t;

endpackage

/* vload_counter.sv */
module vload_counter #(
  parameter int               WIDTH = 4,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Count and zero flag move together so is_zero never lags
  always_ff @(posedge aclk) begin
    if (areset) begin
      count   <= INIT;
      is_zero <= (INIT == '0);
    end else if (load) begin
      count   <= load_value;
      is_zero <= (load_value == '0);
    end else if (incr && !decr) begin
      count   <= count + 1'b1;
      // Only a wrap from all ones lands on zero
      is_zero <= (count == '1);
    end else if (decr && !incr) begin
      count   <= count - 1'b1;
      is_zero <= (count == WIDTH'(1));
    end
    // Simultaneous incr and decr cancel out
  end

endmodule

/* vload_axi_read_master.sv */
`include "vload_cfg.svh"

module vload_axi_read_master
  import vload_pkg::*;
(
  input  logic      aclk,
  input  logic      areset,
  input  logic      start,
  input  load_req_t req,
  output logic      done,
  output logic      arvalid,
  input  logic      arready,
  output axi_ar_t   ar,
  input  logic      rvalid,
  input  logic      rready,
  input  logic      rlast
);

  ////////////////////////////////////////////////////////////
  // Derived sizes
  ////////////////////////////////////////////////////////////

  localparam int DW_BYTES      = `VLOAD_DATA_W / 8;
  localparam int LOG_DW_BYTES  = $clog2(DW_BYTES);
  localparam int LOG_BURST_LEN = $clog2(`VLOAD_BURST_LEN);
  localparam int BURST_BYTES   = DW_BYTES * `VLOAD_BURST_LEN;
  // Beats minus one, in beat units
  localparam int TOTAL_LEN_W   = `VLOAD_ADDR_W - LOG_DW_BYTES;
  // Bursts minus one
  localparam int XFER_CNT_W    = TOTAL_LEN_W - LOG_BURST_LEN;
  localparam int OUTST_W       = $clog2(`VLOAD_MAX_OUTSTANDING + 1);

  localparam addr_t ADDR_MASK = addr_t'(BURST_BYTES - 1);

  // Request pipeline
  logic                     start_d1;
  addr_t                    base_addr_r;
  logic [TOTAL_LEN_W-1:0]   total_len_r;
  logic [XFER_CNT_W-1:0]    num_bursts_m1;
  logic [LOG_BURST_LEN-1:0] final_burst_len;
  logic                     ar_active;

  // Address channel
  logic                  arvalid_q;
  addr_t                 ar_addr;
  logic [7:0]            ar_len;
  logic                  arxfer;
  logic [XFER_CNT_W-1:0] ar_to_go;
  logic                  ar_final;
  logic                  ar_done;
  logic                  stall_ar;
  logic [OUTST_W-1:0]    vacancy;

  // Data channel
  logic                  rxfer;
  logic                  r_completed;
  logic [XFER_CNT_W-1:0] r_to_go;
  logic                  r_final;
  logic                  done_q;

  ////////////////////////////////////////////////////////////
  // Request staging
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
    end else begin
      start_d1 <= start;
    end
  end

  // Stage one, round bytes up to beats and align the base down
  always_ff @(posedge aclk) begin
    if (start) begin
      // A partial beat counts as a whole one, stored as beats minus one
      total_len_r <= (req.size[LOG_DW_BYTES-1:0] != '0)
                       ? req.size[LOG_DW_BYTES +: TOTAL_LEN_W]
                       : req.size[LOG_DW_BYTES +: TOTAL_LEN_W] - 1'b1;
      base_addr_r <= req.addr & ~ADDR_MASK;
    end
  end

  // Upper bits give full bursts, lower bits the last burst's arlen
  assign num_bursts_m1 = total_len_r[LOG_BURST_LEN +: XFER_CNT_W];

  // Stage two, counters load and issue opens
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      final_burst_len <= total_len_r[LOG_BURST_LEN-1:0];
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_active <= 1'b0;
    end else if (start_d1) begin
      ar_active <= 1'b1;
    end else if (ar_done) begin
      ar_active <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read address channel
  ////////////////////////////////////////////////////////////

  assign arxfer  = arvalid_q & arready;
  assign ar_done = arxfer & ar_final;

  // Only the final burst may be short
  assign ar_len = ar_final ? 8'(final_burst_len) : 8'(`VLOAD_BURST_LEN - 1);

  assign arvalid = arvalid_q;
  assign ar      = '{addr: ar_addr, len: ar_len};

  // Valid rises from idle only, so one bubble follows each handshake
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid_q <= 1'b0;
    end else if (ar_active && !stall_ar && !arvalid_q) begin
      arvalid_q <= 1'b1;
    end else if (arready) begin
      arvalid_q <= 1'b0;
    end
  end

  // Step one full burst per accepted AR
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      ar_addr <= base_addr_r;
    end else if (arxfer) begin
      ar_addr <= ar_addr + addr_t'(BURST_BYTES);
    end
  end

  // Bursts left to issue, zero flags the final one
  vload_counter #(
    .WIDTH (XFER_CNT_W),
    .INIT  ('0)
  ) i_ar_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start_d1),
    .incr       (1'b0),
    .decr       (arxfer & ~ar_final),
    .load_value (num_bursts_m1),
    .count      (ar_to_go),
    .is_zero    (ar_final)
  );

  // Free slots for bursts in flight
  vload_counter #(
    .WIDTH (OUTST_W),
    .INIT  (OUTST_W'(`VLOAD_MAX_OUTSTANDING))
  ) i_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (r_completed),
    .decr       (arxfer),
    .load_value ('0),
    .count      (vacancy),
    .is_zero    (stall_ar)
  );

  ////////////////////////////////////////////////////////////
  // Read data channel
  ////////////////////////////////////////////////////////////

  assign rxfer       = rvalid & rready;
  assign r_completed = rxfer & rlast;

  // Bursts left to complete
  vload_counter #(
    .WIDTH (XFER_CNT_W),
    .INIT  ('0)
  ) i_r_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start_d1),
    .incr       (1'b0),
    .decr       (r_completed & ~r_final),
    .load_value (num_bursts_m1),
    .count      (r_to_go),
    .is_zero    (r_final)
  );

  // One cycle after the last beat of the last burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      done_q <= 1'b0;
    end else begin
      done_q <= r_completed & r_final;
    end
  end

  assign done = done_q;

  // Payload frozen while the slave stalls
  a_ar_hold: assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(ar));

  a_vacancy_max: assert property (@(posedge aclk) disable iff (areset)
    vacancy <= OUTST_W'(`VLOAD_MAX_OUTSTANDING));

  // A burst cannot complete before it is issued
  a_issue_order: assert property (@(posedge aclk) disable iff (areset)
    ar_to_go <= r_to_go);

endmodule

/* vload_apb_regs.sv */
`include "vload_cfg.svh"

module vload_apb_regs
  import vload_pkg::*;
(
  input  logic        aclk,
  input  logic        areset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  apb_word_t   pwdata,
  output apb_word_t   prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        start,
  output load_req_t   req,
  input  logic        done,
  output logic        clear,
  output logic        busy,
  input  beat_cnt_t   beats,
  output vrf_idx_t    rd_idx,
  input  data_t       rd_data
);

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam logic [11:0] REG_CTRL   = 12'h000;
  localparam logic [11:0] REG_STATUS = 12'h004;
  localparam logic [11:0] REG_ADDR   = 12'h008;
  localparam logic [11:0] REG_SIZE   = 12'h00C;
  localparam logic [11:0] REG_BEATS  = 12'h010;
  localparam logic [11:0] WIN_BASE   = 12'h100;

  localparam int WORD_BYTES = `VLOAD_DATA_W / 8;
  localparam int MAX_BYTES  = `VLOAD_VRF_WORDS * WORD_BYTES;
  localparam logic [11:0] WIN_END = WIN_BASE + 12'(MAX_BYTES);

  ctrl_state_t state;
  addr_t       addr_r;
  addr_t       size_r;
  logic        done_flag;
  logic        start_q;
  logic        wr_access;
  logic        start_wr;
  logic        refuse;
  logic [11:0] win_off;
  logic        in_window;

  // Zero wait states on every access
  assign pready    = 1'b1;
  assign wr_access = psel & penable & pwrite;

  // Start request and its checks
  assign start_wr = wr_access && (paddr == REG_CTRL) && pwdata[0];
  assign refuse   = (size_r == '0) || (size_r > addr_t'(MAX_BYTES)) || busy || start_q;
  assign pslverr  = start_wr & refuse;

  always_ff @(posedge aclk) begin
    if (areset) begin
      addr_r <= '0;
      size_r <= '0;
    end else if (wr_access) begin
      if (paddr == REG_ADDR) begin
        addr_r <= addr_t'(pwdata);
      end
      if (paddr == REG_SIZE) begin
        size_r <= addr_t'(pwdata);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  // Start pulse the cycle after an accepted CTRL write
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_wr & ~refuse;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= CTRL_IDLE;
    end else begin
      case (state)
        CTRL_IDLE: if (start_q) state <= CTRL_BUSY;
        CTRL_BUSY: if (done) state <= CTRL_IDLE;
        default:   state <= CTRL_IDLE;
      endcase
    end
  end

  // Sticky done, dropped by the next start
  always_ff @(posedge aclk) begin
    if (areset) begin
      done_flag <= 1'b0;
    end else if (start_q) begin
      done_flag <= 1'b0;
    end else if (done) begin
      done_flag <= 1'b1;
    end
  end

  assign busy  = (state == CTRL_BUSY);
  assign start = start_q;
  // Buffer pointer restarts on the same edge as the master
  assign clear = start_q;
  assign req   = '{addr: addr_r, size: size_r};

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  assign win_off   = paddr - WIN_BASE;
  assign in_window = (paddr >= WIN_BASE) && (paddr < WIN_END);
  assign rd_idx    = win_off[$clog2(WORD_BYTES) +: $bits(vrf_idx_t)];

  always_comb begin
    prdata = '0;
    if (in_window) begin
      // paddr bit 2 picks the high half
      prdata = paddr[2] ? rd_data[63:32] : rd_data[31:0];
    end else begin
      case (paddr)
        REG_STATUS: prdata = {30'd0, done_flag, busy};
        REG_ADDR:   prdata = apb_word_t'(addr_r);
        REG_SIZE:   prdata = apb_word_t'(size_r);
        REG_BEATS:  prdata = apb_word_t'(beats);
        default:    prdata = '0;
      endcase
    end
  end

  a_start_idle: assert property (@(posedge aclk) disable iff (areset)
    start |-> state == CTRL_IDLE);

  // The master finishes only a load this block launched
  a_done_busy: assert property (@(posedge aclk) disable iff (areset)
    done |-> state == CTRL_BUSY);

endmodule

/* vload_vrf_writer.sv */
`include "vload_cfg.svh"

module vload_vrf_writer
  import vload_pkg::*;
(
  input  logic      aclk,
  input  logic      areset,
  input  logic      clear,
  input  logic      busy,
  input  logic      rvalid,
  input  axi_r_t    r,
  output logic      rready,
  output beat_cnt_t beats,
  input  vrf_idx_t  rd_idx,
  output data_t     rd_data
);

  localparam int LOG_BURST_LEN = $clog2(`VLOAD_BURST_LEN);

  // Single vector register, no reset on contents
  data_t     mem [`VLOAD_VRF_WORDS];
  beat_cnt_t wr_ptr;
  logic      beat_xfer;
  logic      room;

  // Ready for the whole load, never throttles
  assign rready    = busy;
  assign beat_xfer = rvalid & rready;
  assign room      = (wr_ptr < beat_cnt_t'(`VLOAD_VRF_WORDS));

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
    end else if (beat_xfer && room) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Beats land in arrival order
  always_ff @(posedge aclk) begin
    if (beat_xfer && room) begin
      mem[wr_ptr[$bits(vrf_idx_t)-1:0]] <= r.data;
    end
  end

  assign beats   = wr_ptr;
  assign rd_data = mem[rd_idx];

  // Size check upstream keeps loads within the buffer
  a_no_overflow: assert property (@(posedge aclk) disable iff (areset)
    beat_xfer |-> room);

  // A short burst is the final one, nothing follows it in this load
  a_short_last: assert property (@(posedge aclk) disable iff (areset)
    beat_xfer && r.last && (wr_ptr[LOG_BURST_LEN-1:0] != '1)
    |=> !beat_xfer until clear);

endmodule

/* vload_top.sv */
module vload_top
  import vload_pkg::*;
(
  input  logic        aclk,
  input  logic        areset,
  // APB control
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  apb_word_t   pwdata,
  output apb_word_t   prdata,
  output logic        pready,
  output logic        pslverr,
  // AXI read address
  output logic        arvalid,
  input  logic        arready,
  output axi_ar_t     ar,
  // AXI read data
  input  logic        rvalid,
  output logic        rready,
  input  axi_r_t      r
);

  logic      start;
  logic      clear;
  logic      done;
  logic      busy;
  load_req_t req;
  beat_cnt_t beats;
  vrf_idx_t  rd_idx;
  data_t     rd_data;

  ////////////////////////////////////////////////////////////
  // Control, fetch and buffer
  ////////////////////////////////////////////////////////////

  vload_apb_regs i_regs (
    .aclk    (aclk),
    .areset  (areset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .req     (req),
    .done    (done),
    .clear   (clear),
    .busy    (busy),
    .beats   (beats),
    .rd_idx  (rd_idx),
    .rd_data (rd_data)
  );

  // Master sees rready so burst completion matches the writer
  vload_axi_read_master i_master (
    .aclk    (aclk),
    .areset  (areset),
    .start   (start),
    .req     (req),
    .done    (done),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .rlast   (r.last)
  );

  vload_vrf_writer i_writer (
    .aclk    (aclk),
    .areset  (areset),
    .clear   (clear),
    .busy    (busy),
    .rvalid  (rvalid),
    .r       (r),
    .rready  (rready),
    .beats   (beats),
    .rd_idx  (rd_idx),
    .rd_data (rd_data)
  );

endmodule

/* tb_vload_checker.sv */
`include "vload_cfg.svh"

module tb_vload_checker
  import vload_pkg::*;
(
  input  logic        aclk,
  input  logic        areset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  apb_word_t   pwdata,
  input  apb_word_t   prdata,
  input  logic        pready,
  input  logic        pslverr,
  input  logic        arvalid,
  input  logic        arready,
  input  axi_ar_t     ar,
  input  logic        rvalid,
  input  logic        rready,
  input  axi_r_t      r,
  output int          errors
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BURST_BEATS = `VLOAD_BURST_LEN;
  localparam int BURST_BYTES = BURST_BEATS * 8;
  localparam int MAX_BYTES   = `VLOAD_VRF_WORDS * 8;

  // Reference copy of the request registers and the load in progress
  addr_t   m_addr;
  addr_t   m_size;
  logic    m_busy;
  int      m_beats;
  int      m_bursts_left;
  int      in_flight;
  data_t   m_words [`VLOAD_VRF_WORDS];
  axi_ar_t exp_ar [$];

  initial errors = 0;

  // Same memory image as the AXI model in the testbench top
  function automatic data_t mem_word(input addr_t a);
    return {a ^ 32'h9E37_79B9, (a << 5) ^ 32'h5BD1_E995};
  endfunction

  task automatic report_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
    errors++;
    $display("FAILED t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
  endtask

  task automatic report_event(input string what);
    errors++;
    $display("Error at t=%0t: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Expected bursts and buffer contents of an accepted start
  ////////////////////////////////////////////////////////////

  task automatic model_start();
    addr_t base;
    int    full;
    int    rem;
    // Base aligned down to a burst and bytes rounded up to beats
    base    = m_addr & ~addr_t'(BURST_BYTES - 1);
    m_beats = (int'(m_size) + 7) / 8;
    full    = m_beats / BURST_BEATS;
    rem     = m_beats % BURST_BEATS;
    for (int i = 0; i < full; i++) begin
      exp_ar.push_back('{addr: base + addr_t'(BURST_BYTES * i), len: 8'(BURST_BEATS - 1)});
    end
    // Short tail burst
    if (rem != 0) begin
      exp_ar.push_back('{addr: base + addr_t'(BURST_BYTES * full), len: 8'(rem - 1)});
    end
    m_bursts_left = full + ((rem != 0) ? 1 : 0);
    for (int i = 0; i < m_beats; i++) begin
      m_words[i] = mem_word(base + addr_t'(8 * i));
    end
    m_busy = 1'b1;
  endtask

  task automatic check_read();
    int        idx;
    data_t     w;
    apb_word_t exp_rd;
    if (paddr == 12'h010) begin
      if (prdata !== apb_word_t'(m_beats)) report_value("prdata BEATS", m_beats, prdata);
      if (exp_ar.size() != 0) report_event("BEATS read while bursts were never issued");
    end else if (paddr == 12'h004) begin
      if (m_busy && prdata[0] !== 1'b1) report_event("STATUS shows idle during a load");
      if (m_busy && prdata[1] === 1'b1) report_event("STATUS shows done before the last burst");
    end else if (paddr >= 12'h100) begin
      idx = int'((paddr - 12'h100) >> 3);
      // Only words written by the last load are defined
      if (idx < m_beats) begin
        w      = m_words[idx];
        exp_rd = paddr[2] ? w[63:32] : w[31:0];
        if (prdata !== exp_rd) begin
          report_value($sformatf("prdata word %0d", idx), exp_rd, prdata);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Port watch on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    logic    start_req;
    logic    want_err;
    axi_ar_t want;
    if (areset) begin
      m_addr        = '0;
      m_size        = '0;
      m_busy        = 1'b0;
      m_beats       = 0;
      m_bursts_left = 0;
      in_flight     = 0;
      exp_ar.delete();
    end else begin
      // APB access phase
      if (psel && penable) begin
        // Zero wait states on every access
        if (pready !== 1'b1) report_value("pready", 1'b1, pready);
        start_req = pwrite && (paddr == 12'h000) && pwdata[0];
        want_err  = start_req && (m_size == '0 || m_size > addr_t'(MAX_BYTES) || m_busy);
        if (pslverr !== want_err) report_value("pslverr", want_err, pslverr);
        if (pwrite) begin
          if (paddr == 12'h008) m_addr = addr_t'(pwdata);
          if (paddr == 12'h00C) m_size = addr_t'(pwdata);
          if (start_req && !want_err) model_start();
        end else begin
          check_read();
        end
      end
      // Refused starts and idle time must leave AR quiet
      if (arvalid && exp_ar.size() == 0) begin
        report_event("arvalid raised with no burst expected");
      end else if (arvalid && arready) begin
        want = exp_ar.pop_front();
        if (ar.addr !== want.addr) report_value("ar.addr", want.addr, ar.addr);
        if (ar.len !== want.len) report_value("ar.len", want.len, ar.len);
      end
      // Beats of an issued burst are never throttled
      if (in_flight > 0 && rready !== 1'b1) report_value("rready", 1'b1, rready);
      if (arvalid && arready) in_flight++;
      if (rvalid && rready && r.last) begin
        in_flight--;
        if (m_bursts_left > 0) m_bursts_left--;
        if (m_bursts_left == 0) m_busy = 1'b0;
      end
      if (in_flight > `VLOAD_MAX_OUTSTANDING) begin
        report_event($sformatf("%0d bursts in flight, limit exceeded", in_flight));
      end
    end
  end

endmodule

/* tb_vload_top.sv */
`include "vload_cfg.svh"

module tb_vload_top
  import vload_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED       = 32'd89682;
  localparam int          POLL_LIMIT = 2000;
  localparam logic [11:0] REG_CTRL   = 12'h000;
  localparam logic [11:0] REG_STATUS = 12'h004;
  localparam logic [11:0] REG_ADDR   = 12'h008;
  localparam logic [11:0] REG_SIZE   = 12'h00C;
  localparam logic [11:0] REG_BEATS  = 12'h010;

  logic        aclk;
  logic        areset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  apb_word_t   pwdata;
  apb_word_t   prdata;
  logic        pready;
  logic        pslverr;
  logic        arvalid;
  logic        arready = 1'b0;
  axi_ar_t     ar;
  logic        rvalid = 1'b0;
  logic        rready;
  axi_r_t      r = '0;

  int          errors;
  int          timeouts;
  // Separate streams so stimulus and back-pressure never share draws
  int unsigned stim_seed = SEED;
  int unsigned bp_seed = SEED * 3 + 1;
  axi_ar_t     ar_q [$];
  int          beat_i;

  vload_top i_dut (.*);

  tb_vload_checker i_checker (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned next_stim();
    stim_seed = lcg_next(stim_seed);
    return stim_seed >> 8;
  endfunction

  function automatic int unsigned next_bp();
    bp_seed = lcg_next(bp_seed);
    return bp_seed >> 8;
  endfunction

  // Word at byte address a, depends on every address bit
  function automatic data_t mem_word(input addr_t a);
    return {a ^ 32'h9E37_79B9, (a << 5) ^ 32'h5BD1_E995};
  endfunction

  ////////////////////////////////////////////////////////////
  // AXI memory model
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    axi_ar_t cur;
    if (areset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      beat_i = 0;
      ar_q.delete();
    end else begin
      if (arvalid && arready) ar_q.push_back(ar);
      if (rvalid && rready) begin
        if (r.last) begin
          void'(ar_q.pop_front());
          beat_i = 0;
        end else begin
          beat_i++;
        end
      end
      arready <= (next_bp() % 4) != 0;
      // A beat on offer stays put until taken
      if (rvalid && !rready) begin
        rvalid <= 1'b1;
      end else if (ar_q.size() != 0 && (next_bp() % 3) != 0) begin
        cur = ar_q[0];
        rvalid <= 1'b1;
        r <= '{data: mem_word(cur.addr + addr_t'(8 * beat_i)), last: (beat_i == int'(cur.len))};
      end else begin
        rvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////

  // Setup cycle then one access cycle, response sampled mid access
  task automatic apb_access(input logic wr, input logic [11:0] a, input apb_word_t wd,
                            output apb_word_t rd);
    @(posedge aclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= wd;
    @(posedge aclk);
    penable <= 1'b1;
    @(negedge aclk);
    rd = prdata;
    @(posedge aclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] a, input apb_word_t wd);
    apb_word_t unused;
    apb_access(1'b1, a, wd, unused);
  endtask

  task automatic apb_read(input logic [11:0] a, output apb_word_t rd);
    apb_access(1'b0, a, '0, rd);
  endtask

  task automatic set_request(input addr_t a, input addr_t size);
    apb_write(REG_ADDR, apb_word_t'(a));
    apb_write(REG_SIZE, apb_word_t'(size));
  endtask

  // Poll STATUS until the done bit, bounded by POLL_LIMIT
  task automatic wait_done();
    apb_word_t st;
    int        polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < POLL_LIMIT) begin
      apb_read(REG_STATUS, st);
      polls++;
    end
    if (!st[1]) begin
      timeouts++;
      $display("Timeout: load not done after %0d STATUS polls", polls);
    end
  endtask

  task automatic read_back(input int words);
    apb_word_t v;
    apb_read(REG_BEATS, v);
    for (int i = 0; i < words; i++) begin
      apb_read(12'h100 + 12'(8 * i), v);
      apb_read(12'h104 + 12'(8 * i), v);
    end
  endtask

  task automatic run_load(input addr_t a, input addr_t size);
    set_request(a, size);
    apb_write(REG_CTRL, 32'd1);
    wait_done();
    if (timeouts == 0) read_back((int'(size) + 7) / 8);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    apb_word_t st;
    timeouts = 0;
    areset   = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    repeat (3) @(posedge aclk);
    areset <= 1'b0;
    // One full aligned burst, then four bursts with a one beat tail
    run_load(32'h0000_2000, 32'd128);
    if (timeouts == 0) run_load(32'h0001_0000, 32'd392);
    // Unaligned base and a partial last beat
    if (timeouts == 0) run_load(32'h0000_3456, 32'd61);
    for (int n = 0; n < 6 && timeouts == 0; n++) begin
      run_load(addr_t'(next_stim()), addr_t'(1 + next_stim() % 512));
    end
    // Bad sizes are refused
    if (timeouts == 0) begin
      set_request(32'h0000_4000, 32'd0);
      apb_write(REG_CTRL, 32'd1);
      set_request(32'h0000_4000, 32'd520);
      apb_write(REG_CTRL, 32'd1);
      // Second start lands while the first load runs
      set_request(32'h0000_5000, 32'd512);
      apb_write(REG_CTRL, 32'd1);
      apb_write(REG_CTRL, 32'd1);
      apb_read(REG_STATUS, st);
      wait_done();
      if (timeouts == 0) read_back(64);
    end
    repeat (4) @(posedge aclk);
    $display("Checks finished: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* vload_top.f */
+incdir+.
vload_pkg.sv
vload_counter.sv
vload_axi_read_master.sv
vload_apb_regs.sv
vload_vrf_writer.sv
vload_top.sv
tb_vload_checker.sv
tb_vload_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_vload_top -f vload_top.f -o sim_vload &&
  { out=$(./obj_dir/sim_vload 2>&1); echo "$out"; } &&
  echo "$out" | grep -q "All tests passed" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
